// ==== hdl/phold_pkg.sv ====
package phold_pkg;

   // message layout
   localparam int MSG_WID  = 32;
   localparam int TIME_WID = 16;
   localparam int NB_LPID  = 3;

   // random word and the fields carved out of it
   localparam int NB_RND        = 24;
   localparam int RND_FIELD_WID = NB_RND / 3;
   localparam int TIME_INC_WID  = 6;
   localparam int DELAY_SEL_WID = 4;

   typedef logic [TIME_WID-1:0] sim_time_t;
   typedef logic [NB_LPID-1:0]  lp_id_t;

   typedef enum logic {
      REGULAR_EVT = 1'b0,
      CANCEL_EVT  = 1'b1
   } evt_type_e;

   // bit 19 type, 18..16 target, 15..0 timestamp
   typedef struct packed {
      logic [MSG_WID-TIME_WID-NB_LPID-2:0] pad;
      evt_type_e                           evt_type;
      lp_id_t                              target;
      sim_time_t                           timestamp;
   } event_msg_t;

   // delay_sel from bits 19..16, target_sel from 10..8, time_inc from 5..0
   typedef struct packed {
      logic [DELAY_SEL_WID-1:0] delay_sel;
      lp_id_t                   target_sel;
      logic [TIME_INC_WID-1:0]  time_inc;
   } rnd_fields_t;

   // decoded event held while it is being processed
   typedef struct packed {
      lp_id_t      lp;
      sim_time_t   timestamp;
      evt_type_e   evt_type;
      rnd_fields_t rnd;
   } event_info_t;

endpackage

// ==== hdl/event_decode.sv ====
`timescale 1ns/1ps

module event_decode #(
   parameter int CNT_WID = 16
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            event_valid,
   input  phold_pkg::event_msg_t           cur_event_msg,
   input  logic [phold_pkg::NB_RND-1:0]    random_in,
   input  logic                            stall,
   input  logic                            done,
   output logic                            ready,
   output logic                            start,
   output phold_pkg::event_info_t          cur_event,
   output logic [CNT_WID-1:0]              stall_time
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STALL,
      ST_BUSY
   } state_e;

   state_e state;
   logic   stall_q;
   logic   accept;

   assign ready  = (state == ST_IDLE);
   assign accept = event_valid && ready;

   // first cycle with the registered stall clear
   assign start = (state == ST_STALL) && !stall_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         stall_q <= 1'b0;
      end else begin
         stall_q <= stall;
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  state <= ST_STALL;
               end
            end
            ST_STALL: begin
               if (!stall_q) begin
                  state <= ST_BUSY;
               end
            end
            ST_BUSY: begin
               // done arrives on the output ack edge
               if (done) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // capture message and random fields with the event
   always_ff @(posedge clk) begin
      if (accept) begin
         cur_event.lp                <= cur_event_msg.target;
         cur_event.timestamp         <= cur_event_msg.timestamp;
         cur_event.evt_type          <= cur_event_msg.evt_type;
         cur_event.rnd.delay_sel     <=
            random_in[2*phold_pkg::RND_FIELD_WID +: phold_pkg::DELAY_SEL_WID];
         cur_event.rnd.target_sel    <=
            random_in[phold_pkg::RND_FIELD_WID +: phold_pkg::NB_LPID];
         cur_event.rnd.time_inc      <= random_in[0 +: phold_pkg::TIME_INC_WID];
      end
   end

   // stall cycles of the current event
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stall_time <= '0;
      end else if (accept) begin
         stall_time <= '0;
      end else if (state == ST_STALL && stall_q) begin
         stall_time <= stall_time + 1'b1;
      end
   end

endmodule

// ==== hdl/event_execute.sv ====
`timescale 1ns/1ps

module event_execute #(
   parameter int MIN_GAP   = 10,
   parameter int DELAY_WID = 9
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   start,
   input  phold_pkg::event_info_t cur_event,
   input  phold_pkg::lp_id_t      lp_mask,
   input  logic [7:0]             fixed_delay,
   output logic                   gen_valid,
   output phold_pkg::event_msg_t  gen_msg
);

   logic [DELAY_WID-1:0]  delay_cnt;
   logic [DELAY_WID-1:0]  delay_target;
   logic                  active;
   phold_pkg::event_msg_t next_msg;

   // random nibble plus the fixed part
   assign delay_target = DELAY_WID'(cur_event.rnd.delay_sel) + DELAY_WID'(fixed_delay);

   assign gen_valid = active && (delay_cnt == delay_target);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active    <= 1'b0;
         delay_cnt <= '0;
      end else if (start) begin
         active    <= 1'b1;
         delay_cnt <= '0;
      end else if (active) begin
         if (delay_cnt == delay_target) begin
            active <= 1'b0;
         end else begin
            delay_cnt <= delay_cnt + 1'b1;
         end
      end
   end

   // new regular event, or the null message for a cancellation
   always_comb begin
      next_msg = '0;
      if (cur_event.evt_type == phold_pkg::REGULAR_EVT) begin
         next_msg.evt_type  = phold_pkg::REGULAR_EVT;
         next_msg.target    = cur_event.rnd.target_sel & lp_mask;
         // wraps at 2^16
         next_msg.timestamp = cur_event.timestamp
                            + phold_pkg::sim_time_t'(MIN_GAP)
                            + phold_pkg::sim_time_t'(cur_event.rnd.time_inc);
      end else begin
         next_msg.evt_type = phold_pkg::CANCEL_EVT;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         gen_msg <= next_msg;
      end
   end

endmodule

// ==== hdl/event_result.sv ====
`timescale 1ns/1ps

module event_result #(
   parameter int CNT_WID = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  logic                  gen_valid,
   input  phold_pkg::event_msg_t gen_msg,
   input  logic                  ack,
   output logic                  new_event_ready,
   output phold_pkg::event_msg_t out_event_msg,
   output logic                  done,
   output logic [CNT_WID-1:0]    proc_time
);

   logic counting;

   // handshake completes on this edge
   assign done = new_event_ready && ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         new_event_ready <= 1'b0;
      end else if (gen_valid) begin
         new_event_ready <= 1'b1;
      end else if (done) begin
         new_event_ready <= 1'b0;
      end
   end

   // held until the ack edge
   always_ff @(posedge clk) begin
      if (gen_valid) begin
         out_event_msg <= gen_msg;
      end
   end

   // the start cycle counts as the first one
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         counting  <= 1'b0;
         proc_time <= '0;
      end else if (start) begin
         counting  <= 1'b1;
         proc_time <= CNT_WID'(1);
      end else if (counting) begin
         proc_time <= proc_time + 1'b1;
         if (done) begin
            counting <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/phold_core.sv ====
`timescale 1ns/1ps

module phold_core #(
   parameter int MIN_GAP   = 10,
   parameter int CNT_WID   = 16,
   parameter int DELAY_WID = 9
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         event_valid,
   input  phold_pkg::event_msg_t        cur_event_msg,
   input  logic [phold_pkg::NB_RND-1:0] random_in,
   input  phold_pkg::lp_id_t            lp_mask,
   input  logic [7:0]                   fixed_delay,
   input  logic                         stall,
   input  logic                         ack,
   output logic                         ready,
   output logic                         new_event_ready,
   output phold_pkg::event_msg_t        out_event_msg,
   output logic [CNT_WID-1:0]           stall_time,
   output logic [CNT_WID-1:0]           proc_time
);

   logic                   start;
   logic                   done;
   logic                   gen_valid;
   phold_pkg::event_info_t cur_event;
   phold_pkg::event_msg_t  gen_msg;

   // intake, random capture and stall wait
   event_decode #(
      .CNT_WID (CNT_WID)
   ) u_decode (
      .clk           (clk),
      .rst_n         (rst_n),
      .event_valid   (event_valid),
      .cur_event_msg (cur_event_msg),
      .random_in     (random_in),
      .stall         (stall),
      .done          (done),
      .ready         (ready),
      .start         (start),
      .cur_event     (cur_event),
      .stall_time    (stall_time)
   );

   event_execute #(
      .MIN_GAP   (MIN_GAP),
      .DELAY_WID (DELAY_WID)
   ) u_execute (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (start),
      .cur_event   (cur_event),
      .lp_mask     (lp_mask),
      .fixed_delay (fixed_delay),
      .gen_valid   (gen_valid),
      .gen_msg     (gen_msg)
   );

   // output hold until ack
   event_result #(
      .CNT_WID (CNT_WID)
   ) u_result (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .gen_valid       (gen_valid),
      .gen_msg         (gen_msg),
      .ack             (ack),
      .new_event_ready (new_event_ready),
      .out_event_msg   (out_event_msg),
      .done            (done),
      .proc_time       (proc_time)
   );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 20
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

// ==== verif/phold_core_props.sv ====
`timescale 1ns/1ps

module phold_core_props (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  ready,
   input logic                  new_event_ready,
   input logic                  ack,
   input phold_pkg::event_msg_t out_event_msg
);

   // output waits for the ack
   hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
      new_event_ready && !ack |=> new_event_ready && $stable(out_event_msg))
      else $error("new_event_ready or out_event_msg changed while ack was low");

   // only one event in flight
   no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
      !(ready && new_event_ready))
      else $error("ready and new_event_ready high in the same cycle");

   ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> ready)
      else $error("ready low in the first cycle after reset");

endmodule

bind phold_core phold_core_props u_props (
   .clk             (clk),
   .rst_n           (rst_n),
   .ready           (ready),
   .new_event_ready (new_event_ready),
   .ack             (ack),
   .out_event_msg   (out_event_msg)
);

// ==== verif/tb_phold_core.sv ====
`timescale 1ns/1ps

module tb_phold_core;

   localparam int N_EVENTS    = 26;
   // stall hold 8 + longest delay 271 + ack hold 8 + handshake cycles
   localparam int MAX_LAT     = 8 + 271 + 8 + 4;
   localparam int CYCLE_LIMIT = N_EVENTS * MAX_LAT + 100;

   logic                         clk;
   logic                         rst_n;
   logic                         event_valid;
   phold_pkg::event_msg_t        cur_event_msg;
   logic [phold_pkg::NB_RND-1:0] random_in;
   phold_pkg::lp_id_t            lp_mask;
   logic [7:0]                   fixed_delay;
   logic                         stall;
   logic                         ack;
   logic                         ready;
   logic                         new_event_ready;
   phold_pkg::event_msg_t        out_event_msg;
   logic [15:0]                  stall_time;
   logic [15:0]                  proc_time;

   logic [31:0] lfsr = 32'h85cd6ff8;
   int          errors = 0;
   int          checks = 0;
   int          reported = 0;
   int          cycles = 0;

   tb_clock_gen #(.PERIOD_NS(20)) u_clk (.clk(clk));

   phold_core u_dut (.*);

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("test failed");
         $finish;
      end
   end

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return val;
   endfunction

   // null message for a cancel, otherwise new target and later timestamp
   function automatic phold_pkg::event_msg_t expected_msg(input phold_pkg::event_msg_t msg,
                                                          input logic [23:0] rnd,
                                                          input phold_pkg::lp_id_t mask);
      phold_pkg::event_msg_t exp_msg;
      exp_msg = '0;
      if (msg.evt_type == phold_pkg::CANCEL_EVT) begin
         exp_msg.evt_type = phold_pkg::CANCEL_EVT;
      end else begin
         exp_msg.target    = rnd[10:8] & mask;
         exp_msg.timestamp = msg.timestamp + 16'd10 + 16'(rnd[5:0]);
      end
      return exp_msg;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic expect_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("[ERROR] %0t ns: %s", $time, what);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      $display("%-14s %0d errors", name, errors - reported);
      reported = errors;
   endtask

   task automatic wait_high(input bit want_ready, output bit seen);
      int waited;
      waited = 0;
      seen   = want_ready ? ready : new_event_ready;
      while (!seen && waited < MAX_LAT) begin
         next_cycle();
         waited++;
         seen = want_ready ? ready : new_event_ready;
      end
      if (!seen) begin
         $display("%s did not go high within %0d cycles",
                  want_ready ? "ready" : "new_event_ready", MAX_LAT);
         errors++;
      end
   endtask

   task automatic run_event(input phold_pkg::event_msg_t msg, input logic [23:0] rnd,
                            input phold_pkg::lp_id_t mask, input logic [7:0] fdly,
                            input int stall_cyc, input int ack_wait);
      phold_pkg::event_msg_t exp_msg;
      bit                    seen;
      exp_msg = expected_msg(msg, rnd, mask);
      wait_high(1'b1, seen);
      if (!seen) return;
      event_valid   = 1'b1;
      cur_event_msg = msg;
      random_in     = rnd;
      lp_mask       = mask;
      fixed_delay   = fdly;
      stall         = (stall_cyc > 0);
      next_cycle();
      // core works from its captured copy
      event_valid   = 1'b0;
      cur_event_msg = phold_pkg::event_msg_t'(~msg);
      random_in     = ~rnd;
      for (int i = 1; i < stall_cyc; i++) begin
         expect_true(!new_event_ready, "new_event_ready high during stall");
         next_cycle();
      end
      stall = 1'b0;
      wait_high(1'b0, seen);
      if (!seen) return;
      expect_true(out_event_msg == exp_msg,
                  $sformatf("out_event_msg %h, expected %h", out_event_msg, exp_msg));
      if (stall_cyc > 1) begin
         expect_true(int'(stall_time) >= stall_cyc - 1,
                     $sformatf("stall_time %0d for %0d stall cycles", stall_time, stall_cyc));
      end
      expect_true(int'(proc_time) >= int'(rnd[19:16]) + int'(fdly) + 2,
                  $sformatf("proc_time %0d too small", proc_time));
      for (int i = 0; i < ack_wait; i++) begin
         next_cycle();
         expect_true(new_event_ready && out_event_msg == exp_msg && !ready,
                     "output not held while ack low");
      end
      ack = 1'b1;
      next_cycle();
      ack = 1'b0;
      expect_true(ready && !new_event_ready, "ready not back one cycle after ack");
   endtask

   task automatic check_after_reset();
      expect_true(ready && !new_event_ready, "handshake outputs wrong after reset");
      expect_true(stall_time == '0 && proc_time == '0, "counters not zero after reset");
      report_test("reset");
   endtask

   task automatic check_regular();
      run_event(phold_pkg::event_msg_t'({12'hABC, 1'b0, 3'd5, 16'h1234}),
                24'h0A0615, 3'b111, 8'd3, 0, 0);
      // timestamp wraps past 16'hffff
      run_event(phold_pkg::event_msg_t'({12'h000, 1'b0, 3'd1, 16'hFFF8}),
                24'h03023F, 3'b101, 8'd0, 0, 0);
      report_test("regular");
   endtask

   task automatic check_cancel();
      run_event(phold_pkg::event_msg_t'({12'h000, 1'b1, 3'd6, 16'h4321}),
                24'h05072A, 3'b111, 8'd2, 0, 0);
      report_test("cancel");
   endtask

   task automatic check_backpressure();
      run_event(phold_pkg::event_msg_t'({12'h000, 1'b0, 3'd2, 16'h0100}),
                24'h0C0411, 3'b011, 8'd4, 0, 6);
      run_event(phold_pkg::event_msg_t'({12'h000, 1'b0, 3'd3, 16'h0200}),
                24'h010722, 3'b111, 8'd1, 0, 0);
      report_test("backpressure");
   endtask

   task automatic check_stall();
      // short delay so an early output would land inside the stall
      run_event(phold_pkg::event_msg_t'({12'h000, 1'b0, 3'd4, 16'h8000}),
                24'h010509, 3'b110, 8'd0, 5, 1);
      report_test("stall");
   endtask

   task automatic check_random_events();
      logic [31:0] fields;
      logic [31:0] rnd;
      logic [31:0] knobs;
      for (int n = 0; n < 20; n++) begin
         fields = take_bits(20);
         rnd    = take_bits(24);
         knobs  = take_bits(15);
         run_event(phold_pkg::event_msg_t'({12'h000, fields[19:0]}), rnd[23:0], knobs[2:0],
                   knobs[10:3], int'(knobs[12:11]), int'(knobs[14:13]));
      end
      report_test("random");
   endtask

   initial begin
      rst_n         = 1'b0;
      event_valid   = 1'b0;
      cur_event_msg = '0;
      random_in     = '0;
      lp_mask       = '0;
      fixed_delay   = '0;
      stall         = 1'b0;
      ack           = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      check_after_reset();
      check_regular();
      check_cancel();
      check_backpressure();
      check_stall();
      check_random_events();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
hdl/phold_pkg.sv
hdl/event_decode.sv
hdl/event_execute.sv
hdl/event_result.sv
hdl/phold_core.sv
verif/tb_clock_gen.sv
verif/phold_core_props.sv
verif/tb_phold_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_phold_core
./obj_dir/Vtb_phold_core 2>&1 | tee sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"
